/* verilog.f */
+incdir+design
+incdir+sim
design/rv_pkg.sv
design/register_file.sv
design/instr_decoder.sv
design/alu.sv
design/execute_stage.sv
design/exec_core.sv
sim/tb_exec_core.sv

/* sim/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// architectural state as the instruction stream should leave it
logic [`XLEN-1:0]       model_regs [0:`NUM_REGS-1];
logic [`XLEN-1:0]       exp_data_q [$];
logic [`REG_ADDR_W-1:0] exp_rd_q [$];
logic                   exp_illegal_q [$];

function automatic void model_execute(input logic [`XLEN-1:0] instr);
  logic [6:0]             opc;
  logic [2:0]             f3;
  logic [6:0]             f7;
  logic [`REG_ADDR_W-1:0] rd;
  logic [`XLEN-1:0]       a;
  logic [`XLEN-1:0]       b;
  logic [`XLEN-1:0]       res;
  logic                   bad;
  opc = instr[6:0];
  rd  = instr[11:7];
  f3  = instr[14:12];
  f7  = instr[31:25];
  a   = model_regs[instr[19:15]];
  b   = model_regs[instr[24:20]];
  res = '0;
  bad = 1'b0;
  if (opc == OPC_LUI) begin
    res = {instr[31:12], 12'h000};
  end else if (opc == OPC_OP || opc == OPC_OP_IMM) begin
    if (opc == OPC_OP_IMM) begin
      b = {{(`XLEN-12){instr[31]}}, instr[31:20]};
      // immediate shifts keep funct7 in the upper immediate bits
      if (f3 == 3'b001) bad = (f7 != 7'h00);
      if (f3 == 3'b101) bad = (f7 != 7'h00 && f7 != 7'h20);
    end else begin
      bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
    end
    case (f3)
      3'b000: res = (opc == OPC_OP && f7 == 7'h20) ? a - b : a + b;
      3'b001: res = a << b[4:0];
      3'b010: res = ($signed(a) < $signed(b)) ? 1 : 0;
      3'b011: res = (a < b) ? 1 : 0;
      3'b100: res = a ^ b;
      3'b101: begin
        res = a >> b[4:0];
        // arithmetic form copies the sign into the vacated upper bits
        if (f7 == 7'h20 && a[`XLEN-1]) res = res | ~({`XLEN{1'b1}} >> b[4:0]);
      end
      3'b110: res = a | b;
      3'b111: res = a & b;
    endcase
  end else begin
    bad = 1'b1;
  end
  if (bad) res = '0;
  if (!bad && rd != '0) model_regs[rd] = res;
  exp_data_q.push_back(res);
  exp_rd_q.push_back(rd);
  exp_illegal_q.push_back(bad);
endfunction

`endif

/* sim/tb_exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module tb_exec_core
  import rv_pkg::*;
();

  localparam int N_INIT = 31;
  localparam int N_MIX = 400;
  localparam int N_X0 = 30;
  localparam int N_LUI = 20;
  localparam int N_ILL = 30;
  localparam int N_BP = 100;
  localparam int N_TOTAL = N_INIT + N_MIX + 2 * N_X0 + N_LUI + 2 * N_ILL + N_BP;
  localparam int CYCLE_LIMIT = 2 * N_TOTAL + 200;

  logic                   clk;
  logic                   rst;
  logic                   in_valid;
  logic                   in_ready;
  logic [`XLEN-1:0]       in_instr;
  logic                   out_valid;
  logic                   out_ready;
  logic [`REG_ADDR_W-1:0] out_rd;
  logic [`XLEN-1:0]       out_data;
  logic                   out_illegal;

  logic [15:0] lfsr = 16'd8467;
  int          cycle_count = 0;
  int          data_errs = 0;
  int          rd_errs = 0;
  int          ill_errs = 0;
  int          hs_errs = 0;
  int          other_errs = 0;
  logic        heavy_bp = 1'b0;
  logic        draining = 1'b0;
  string       test_name = "reset";
  string       name_q [$];
  string       cur_name;

  `include "tb_ref_model.svh"

  exec_core dut (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_instr    (in_instr),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_rd      (out_rd),
    .out_data    (out_data),
    .out_illegal (out_illegal)
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////
  // random numbers and instructions
  ////////////////////////////////////////

  // taps x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [`XLEN-1:0] rand_alu_instr(input logic [4:0] rd);
    logic [2:0]  f3;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [6:0]  f7;
    logic [11:0] imm12;
    f3    = rand_bits(3);
    rs1   = rand_bits(5);
    rs2   = rand_bits(5);
    imm12 = rand_bits(12);
    f7    = (rand_bits(1) && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
    if (rand_bits(1)) return {f7, rs2, rs1, f3, rd, OPC_OP};
    if (f3 == 3'b001 || f3 == 3'b101) return {f7, rs2, rs1, f3, rd, OPC_OP_IMM};
    return {imm12, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  ////////////////////////////////////////
  // driving
  ////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #2;
    if (draining) out_ready = 1'b1;
    else if (heavy_bp) out_ready = rand_bits(1);
    else out_ready = (rand_bits(2) != 0);
  endtask

  task automatic send_instr(input logic [`XLEN-1:0] instr);
    logic took;
    while (rand_bits(3) == 0) begin
      in_valid = 1'b0;
      next_cycle();
    end
    in_valid = 1'b1;
    in_instr = instr;
    do begin
      @(negedge clk);
      took = in_ready;
      next_cycle();
    end while (!took);
    in_valid = 1'b0;
  endtask

  ////////////////////////////////////////
  // checking
  ////////////////////////////////////////

  task automatic check_data(input string name, input logic [`XLEN-1:0] exp,
                            input logic [`XLEN-1:0] act);
    if (act !== exp) begin
      data_errs++;
      $display("** Error %s: out_data expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_rd(input string name, input logic [`REG_ADDR_W-1:0] exp,
                          input logic [`REG_ADDR_W-1:0] act);
    if (act !== exp) begin
      rd_errs++;
      $display("** Error %s: out_rd expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_illegal(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      ill_errs++;
      $display("** Error %s: out_illegal expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_handshake(input string name, input string port, input logic exp,
                                 input logic act);
    if (act !== exp) begin
      hs_errs++;
      $display("** Error %s: %s expected %b actual %b", name, port, exp, act);
    end
  endtask

  // results leave before the new acceptance is queued
  always @(negedge clk) begin
    if (!rst) begin
      // a result is held exactly when the model still owes one
      check_handshake(test_name, "out_valid", exp_data_q.size() != 0, out_valid);
      check_handshake(test_name, "in_ready", exp_data_q.size() == 0 || out_ready, in_ready);
    end
    if (!rst && out_valid && out_ready) begin
      if (exp_data_q.size() == 0) begin
        other_errs++;
        $display("a result came out with no instruction outstanding");
      end else begin
        cur_name = name_q.pop_front();
        check_data(cur_name, exp_data_q.pop_front(), out_data);
        check_rd(cur_name, exp_rd_q.pop_front(), out_rd);
        check_illegal(cur_name, exp_illegal_q.pop_front(), out_illegal);
      end
    end
    if (!rst && in_valid && in_ready) begin
      model_execute(in_instr);
      name_q.push_back(test_name);
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("run timed out after %0d cycles", cycle_count);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    logic [4:0]       t;
    logic [4:0]       r1;
    logic [4:0]       r2;
    logic [2:0]       f3;
    logic [6:0]       f7;
    logic [6:0]       opc;
    logic [11:0]      imm12;
    logic [19:0]      imm20;
    logic [`XLEN-1:0] instr;
    int               kind;
    clk = 1'b0;
    rst = 1'b1;
    in_valid = 1'b0;
    in_instr = '0;
    out_ready = 1'b0;
    for (int i = 0; i < `NUM_REGS; i++) model_regs[i] = '0;
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;

    test_name = "init_fill";
    for (int r = 1; r < `NUM_REGS; r++) begin
      imm12 = rand_bits(12);
      t = r;
      send_instr({imm12, 5'd0, 3'b000, t, OPC_OP_IMM});
    end

    test_name = "random_mix";
    for (int i = 0; i < N_MIX; i++) send_instr(rand_alu_instr(rand_bits(5)));

    // each write to x0 is followed by an or that reads x0 twice
    test_name = "x0_writes";
    for (int i = 0; i < N_X0; i++) begin
      send_instr(rand_alu_instr(5'd0));
      t = rand_bits(5);
      send_instr({7'h00, 5'd0, 5'd0, 3'b110, t, OPC_OP});
    end

    test_name = "lui";
    for (int i = 0; i < N_LUI; i++) begin
      imm20 = rand_bits(20);
      t = rand_bits(5);
      send_instr({imm20, t, OPC_LUI});
    end

    test_name = "illegal";
    for (int i = 0; i < N_ILL; i++) begin
      t = rand_bits(5);
      if (t == 0) t = 5'd1;
      r1 = rand_bits(5);
      r2 = rand_bits(5);
      f3 = rand_bits(3);
      f7 = rand_bits(7) | 7'h01;
      kind = rand_bits(2);
      if (kind == 0) begin
        do opc = rand_bits(7);
        while (opc == OPC_OP || opc == OPC_OP_IMM || opc == OPC_LUI);
        instr = rand_bits(32);
        instr[6:0] = opc;
        instr[11:7] = t;
      end else if (kind == 1) begin
        instr = {f7, r2, r1, f3, t, OPC_OP};
      end else begin
        instr = {f7, r2, r1, (f3[0] ? 3'b001 : 3'b101), t, OPC_OP_IMM};
      end
      send_instr(instr);
      // addi t, t, 0 shows whether t kept its value
      send_instr({12'h000, t, 3'b000, t, OPC_OP_IMM});
    end

    test_name = "back_pressure";
    heavy_bp = 1'b1;
    for (int i = 0; i < N_BP; i++) send_instr(rand_alu_instr(rand_bits(5)));

    draining = 1'b1;
    while (exp_data_q.size() != 0 || out_valid) next_cycle();
    repeat (4) next_cycle();
    if (out_valid) begin
      other_errs++;
      $display("out_valid stayed high after every result was taken");
    end

    $display("errors: data %0d rd %0d illegal %0d handshake %0d other %0d",
             data_errs, rd_errs, ill_errs, hs_errs, other_errs);
    if (data_errs + rd_errs + ill_errs + hs_errs + other_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module exec_core
  import rv_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  logic [`XLEN-1:0]       in_instr,
  output logic                   out_valid,
  input  logic                   out_ready,
  output logic [`REG_ADDR_W-1:0] out_rd,
  output logic [`XLEN-1:0]       out_data,
  output logic                   out_illegal
);

  alu_op_e                dec_alu_op;
  logic                   dec_use_imm;
  logic [`XLEN-1:0]       dec_imm;
  logic [`REG_ADDR_W-1:0] dec_rd;
  logic                   dec_illegal;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;
  alu_op_e                alu_op_sel;
  logic [`XLEN-1:0]       alu_a;
  logic [`XLEN-1:0]       alu_b;
  logic [`XLEN-1:0]       alu_y;
  logic                   wr_ena;
  logic [`REG_ADDR_W-1:0] wr_addr;
  logic [`XLEN-1:0]       wr_data;

  instr_decoder u_decode (
    .instr   (in_instr),
    .alu_op  (dec_alu_op),
    .use_imm (dec_use_imm),
    .imm     (dec_imm),
    .rd      (dec_rd),
    .illegal (dec_illegal)
  );

  // read addresses come straight from the rs1 and rs2 fields
  register_file u_regs (
    .clk      (clk),
    .wr_ena   (wr_ena),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_addr0 (in_instr[19:15]),
    .rd_addr1 (in_instr[24:20]),
    .rd_data0 (rs1_data),
    .rd_data1 (rs2_data)
  );

  alu u_alu (
    .op (alu_op_sel),
    .a  (alu_a),
    .b  (alu_b),
    .y  (alu_y)
  );

  execute_stage u_exec (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .alu_op      (dec_alu_op),
    .use_imm     (dec_use_imm),
    .imm         (dec_imm),
    .rd          (dec_rd),
    .illegal     (dec_illegal),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .alu_op_sel  (alu_op_sel),
    .alu_a       (alu_a),
    .alu_b       (alu_b),
    .alu_y       (alu_y),
    .wr_ena      (wr_ena),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_rd      (out_rd),
    .out_data    (out_data),
    .out_illegal (out_illegal)
  );

endmodule

`default_nettype wire

/* design/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module execute_stage
  import rv_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,

  // instruction side
  input  logic                   in_valid,
  output logic                   in_ready,

  // decoded fields
  input  alu_op_e                alu_op,
  input  logic                   use_imm,
  input  logic [`XLEN-1:0]       imm,
  input  logic [`REG_ADDR_W-1:0] rd,
  input  logic                   illegal,

  // register file read data
  input  logic [`XLEN-1:0]       rs1_data,
  input  logic [`XLEN-1:0]       rs2_data,

  // alu
  output alu_op_e                alu_op_sel,
  output logic [`XLEN-1:0]       alu_a,
  output logic [`XLEN-1:0]       alu_b,
  input  logic [`XLEN-1:0]       alu_y,

  // register file write back
  output logic                   wr_ena,
  output logic [`REG_ADDR_W-1:0] wr_addr,
  output logic [`XLEN-1:0]       wr_data,

  // result side
  output logic                   out_valid,
  input  logic                   out_ready,
  output logic [`REG_ADDR_W-1:0] out_rd,
  output logic [`XLEN-1:0]       out_data,
  output logic                   out_illegal
);

  logic accept;

  ////////////////////////////////////////
  // operands
  ////////////////////////////////////////

  assign alu_op_sel = alu_op;
  assign alu_a      = rs1_data;
  assign alu_b      = use_imm ? imm : rs2_data;

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////

  // the held result frees its slot in the cycle it is taken
  assign in_ready = !out_valid || out_ready;
  assign accept   = in_valid && in_ready;

  // write lands on the accepting edge, so the next instruction sees it
  assign wr_ena  = accept && !illegal && (rd != '0);
  assign wr_addr = rd;
  assign wr_data = alu_y;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // result register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      out_rd      <= rd;
      // illegal encodings report zero data
      out_data    <= illegal ? '0 : alu_y;
      out_illegal <= illegal;
    end
  end

endmodule

`default_nettype wire

/* design/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module alu
  import rv_pkg::*;
(
  input  alu_op_e          op,
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  output logic [`XLEN-1:0] y
);

  logic [`SHAMT_W-1:0] shamt;
  logic [`XLEN-1:0]    sum;
  logic [`XLEN-1:0]    diff;
  logic                lt_signed;
  logic                lt_unsigned;

  ////////////////////////////////////////
  // shared arithmetic
  ////////////////////////////////////////

  // shifts only look at the low bits of b
  assign shamt = b[`SHAMT_W-1:0];

  assign sum  = a + b;
  assign diff = a - b;

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  ////////////////////////////////////////
  // result select
  ////////////////////////////////////////

  always_comb begin
    case (op)
      ALU_ADD: begin
        y = sum;
      end
      ALU_SUB: begin
        y = diff;
      end
      ALU_SLL: begin
        y = a << shamt;
      end
      ALU_SLT: begin
        y = {{(`XLEN-1){1'b0}}, lt_signed};
      end
      ALU_SLTU: begin
        y = {{(`XLEN-1){1'b0}}, lt_unsigned};
      end
      ALU_XOR: begin
        y = a ^ b;
      end
      ALU_SRL: begin
        y = a >> shamt;
      end
      ALU_SRA: begin
        // sign bit fills from the left
        y = $unsigned($signed(a) >>> shamt);
      end
      ALU_OR: begin
        y = a | b;
      end
      ALU_AND: begin
        y = a & b;
      end
      ALU_PASS_B: begin
        y = b;
      end
      default: begin
        y = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module instr_decoder
  import rv_pkg::*;
(
  input  logic [`XLEN-1:0]       instr,
  output alu_op_e                alu_op,
  output logic                   use_imm,
  output logic [`XLEN-1:0]       imm,
  output logic [`REG_ADDR_W-1:0] rd,
  output logic                   illegal
);

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic             f7_zero;
  logic             f7_alt;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_sh;
  logic [`XLEN-1:0] imm_u;

  ////////////////////////////////////////
  // fields and immediates
  ////////////////////////////////////////

  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // alt encoding selects sub and sra
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);

  assign imm_i  = {{(`XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_sh = {{(`XLEN-`SHAMT_W){1'b0}}, instr[20 +: `SHAMT_W]};
  assign imm_u  = {instr[31:12], 12'b0};

  ////////////////////////////////////////
  // operation select
  ////////////////////////////////////////

  always_comb begin
    alu_op  = ALU_ADD;
    use_imm = 1'b0;
    imm     = '0;
    illegal = 1'b0;
    case (opcode)
      OPC_OP: begin
        case (funct3)
          3'b000: alu_op = f7_alt ? ALU_SUB : ALU_ADD;
          3'b001: alu_op = ALU_SLL;
          3'b010: alu_op = ALU_SLT;
          3'b011: alu_op = ALU_SLTU;
          3'b100: alu_op = ALU_XOR;
          3'b101: alu_op = f7_alt ? ALU_SRA : ALU_SRL;
          3'b110: alu_op = ALU_OR;
          3'b111: alu_op = ALU_AND;
        endcase
        // only add/sub and srl/sra accept the alt funct7
        illegal = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        imm     = imm_i;
        case (funct3)
          3'b000: alu_op = ALU_ADD;
          3'b001: begin
            alu_op  = ALU_SLL;
            imm     = imm_sh;
            illegal = !f7_zero;
          end
          3'b010: alu_op = ALU_SLT;
          3'b011: alu_op = ALU_SLTU;
          3'b100: alu_op = ALU_XOR;
          3'b101: begin
            alu_op  = f7_alt ? ALU_SRA : ALU_SRL;
            imm     = imm_sh;
            illegal = !(f7_zero || f7_alt);
          end
          3'b110: alu_op = ALU_OR;
          3'b111: alu_op = ALU_AND;
        endcase
      end
      OPC_LUI: begin
        alu_op  = ALU_PASS_B;
        use_imm = 1'b1;
        imm     = imm_u;
      end
      default: illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* design/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module register_file (
  input  logic                   clk,
  input  logic                   wr_ena,
  input  logic [`REG_ADDR_W-1:0] wr_addr,
  input  logic [`XLEN-1:0]       wr_data,
  input  logic [`REG_ADDR_W-1:0] rd_addr0,
  input  logic [`REG_ADDR_W-1:0] rd_addr1,
  output logic [`XLEN-1:0]       rd_data0,
  output logic [`XLEN-1:0]       rd_data1
);

  // x0 has no storage, it is tied to zero at the read ports
  logic [`XLEN-1:0] words [1:`NUM_REGS-1];
  logic [`NUM_REGS-1:1] word_ena;

  ////////////////////////////////////////
  // write port
  ////////////////////////////////////////

  // one-hot enable, one word per write
  for (genvar i = 1; i < `NUM_REGS; i++) begin : g_word
    assign word_ena[i] = wr_ena && (wr_addr == `REG_ADDR_W'(i));

    always_ff @(posedge clk) begin
      if (word_ena[i]) begin
        words[i] <= wr_data;
      end
    end
  end

  ////////////////////////////////////////
  // read ports
  ////////////////////////////////////////

  function automatic logic [`XLEN-1:0] select_word(input logic [`REG_ADDR_W-1:0] addr);
    logic [`XLEN-1:0] data;
    data = '0;
    for (int i = 1; i < `NUM_REGS; i++) begin
      if (addr == `REG_ADDR_W'(i)) begin
        data = words[i];
      end
    end
    return data;
  endfunction

  always_comb begin
    rd_data0 = select_word(rd_addr0);
    rd_data1 = select_word(rd_addr1);
  end

endmodule

`default_nettype wire

/* design/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  ////////////////////////////////////////
  // major opcodes
  ////////////////////////////////////////

  // only the groups this core executes
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  ////////////////////////////////////////
  // alu operations
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    // second operand straight through, used by lui
    ALU_PASS_B = 4'd10
  } alu_op_e;

endpackage

`default_nettype wire

/* design/rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////

// data width, fixed by RV32I
`define XLEN 32

// shift amount width for XLEN
`define SHAMT_W 5

////////////////////////////////////////
// register file geometry
////////////////////////////////////////

`define REG_ADDR_W 5
`define NUM_REGS 32

`endif
